// ==== lm_pkg.sv ====
`default_nettype none

package lm_pkg;

        // character bigram model
        localparam int alpha_size = 6;
        localparam int char_w     = 3;
        localparam int rom_rows   = alpha_size + 1;   // start row + one per symbol
        localparam int rom_depth  = rom_rows * alpha_size;
        localparam int rom_aw     = $clog2(rom_depth);
        localparam int trans_w    = 16;
        localparam int start_row  = 0;

endpackage

`default_nettype wire

// ==== beam_pkg.sv ====
`default_nettype none

package beam_pkg;

        localparam int n_beam     = 3;
        localparam int prob_w     = 32;
        localparam int score_w    = 64;
        localparam int norm_shift = 21;
        localparam int slot_w     = 8;
        localparam int seq_len    = 15;
        localparam int seq_w      = seq_len * slot_w;
        localparam int cnt_w      = 2;

        // controller states
        localparam logic [1:0] st_idle   = 2'd0;
        localparam logic [1:0] st_score  = 2'd1;
        localparam logic [1:0] st_update = 2'd2;
        localparam logic [1:0] st_top    = 2'd3;

        // index of the largest score, lowest index wins a tie
        function automatic logic [cnt_w-1:0] best_idx(input logic [score_w-1:0] s0,
                                                       input logic [score_w-1:0] s1,
                                                       input logic [score_w-1:0] s2);
                if (s0 >= s1 && s0 >= s2)
                        return cnt_w'(0);
                else if (s1 >= s2)
                        return cnt_w'(1);
                return cnt_w'(2);
        endfunction

endpackage

`default_nettype wire

// ==== bigram_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module bigram_rom import lm_pkg::*; import beam_pkg::*; (
        input  wire  [char_w-1:0]  i_prev0,
        input  wire  [char_w-1:0]  i_prev1,
        input  wire  [char_w-1:0]  i_prev2,
        input  wire  [char_w-1:0]  i_char0,
        input  wire  [char_w-1:0]  i_char1,
        input  wire  [char_w-1:0]  i_char2,
        input  wire  [cnt_w-1:0]   i_cand_idx,
        input  wire                i_seed,
        output logic [trans_w-1:0] o_w0,
        output logic [trans_w-1:0] o_w1,
        output logic [trans_w-1:0] o_w2
);

        logic [trans_w-1:0] weights [rom_depth];
        logic [char_w-1:0]  cand;

        initial $readmemh("bigram_table.hex", weights);

        function automatic logic [rom_aw-1:0] addr(input logic [char_w-1:0] prev,
                                                   input logic [char_w-1:0] col,
                                                   input logic seed);
                logic [rom_aw-1:0] row;
                row = seed ? rom_aw'(start_row) : rom_aw'(prev) + rom_aw'(1);
                return row * rom_aw'(alpha_size) + rom_aw'(col);
        endfunction

        always_comb begin
                case (i_cand_idx)
                        2'd0:    cand = i_char0;
                        2'd1:    cand = i_char1;
                        default: cand = i_char2;   // idx 3 is the drain slot
                endcase
        end

        // seeding reads the start row, one candidate per port
        assign o_w0 = weights[addr(i_prev0, i_seed ? i_char0 : cand, i_seed)];
        assign o_w1 = weights[addr(i_prev1, i_seed ? i_char1 : cand, i_seed)];
        assign o_w2 = weights[addr(i_prev2, i_seed ? i_char2 : cand, i_seed)];

endmodule

`default_nettype wire

// ==== step_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_ctrl import beam_pkg::*; (
        input  wire              i_clk,
        input  wire              i_rst_n,
        input  wire              i_start,
        input  wire              i_next,
        output logic             o_seed_load,
        output logic             o_cand_valid,
        output logic [cnt_w-1:0] o_cand_idx,
        output logic             o_beam_commit,
        output logic             o_top_load
);

        logic [1:0]       state;
        logic [cnt_w-1:0] cnt;
        logic             seed;    // current step is a start step

        always_ff @(posedge i_clk or posedge i_rst_n) begin
                if (i_rst_n) begin
                        state <= st_idle;
                        cnt   <= '0;
                        seed  <= 1'b0;
                end else begin
                        case (state)
                                st_idle: begin
                                        cnt <= '0;
                                        if (i_start) begin      // start beats next
                                                state <= st_score;
                                                seed  <= 1'b1;
                                        end else if (i_next) begin
                                                state <= st_score;
                                                seed  <= 1'b0;
                                        end
                                end
                                st_score: begin
                                        if (seed)
                                                state <= st_top;
                                        else if (cnt == cnt_w'(n_beam))
                                                state <= st_update;   // pipeline drained
                                        else
                                                cnt <= cnt + cnt_w'(1);
                                end
                                st_update: state <= st_top;
                                default:   state <= st_idle;
                        endcase
                end
        end

        assign o_seed_load   = (state == st_score) && seed;
        assign o_cand_valid  = (state == st_score) && !seed && (cnt != cnt_w'(n_beam));
        assign o_cand_idx    = cnt;
        assign o_beam_commit = (state == st_update);
        assign o_top_load    = (state == st_top);

endmodule

`default_nettype wire

// ==== beam_scorer.sv ====
`timescale 1ns/1ps
`default_nettype none

module beam_scorer import lm_pkg::*; import beam_pkg::*; (
        input  wire               i_clk,
        input  wire               i_rst_n,
        input  wire               i_cand_valid,
        input  wire  [cnt_w-1:0]  i_cand_idx,
        input  wire  [prob_w-1:0] i_prob0,
        input  wire  [prob_w-1:0] i_prob1,
        input  wire  [prob_w-1:0] i_prob2,
        input  wire  [char_w-1:0] i_char0,
        input  wire  [char_w-1:0] i_char1,
        input  wire  [char_w-1:0] i_char2,
        input  wire  [score_w-1:0] i_score0,
        input  wire  [score_w-1:0] i_score1,
        input  wire  [score_w-1:0] i_score2,
        input  wire  [seq_w-1:0]   i_seq0,
        input  wire  [seq_w-1:0]   i_seq1,
        input  wire  [seq_w-1:0]   i_seq2,
        input  wire  [trans_w-1:0] i_w0,
        input  wire  [trans_w-1:0] i_w1,
        input  wire  [trans_w-1:0] i_w2,
        output logic [score_w-1:0] o_surv_score0,
        output logic [score_w-1:0] o_surv_score1,
        output logic [score_w-1:0] o_surv_score2,
        output logic [seq_w-1:0]   o_surv_seq0,
        output logic [seq_w-1:0]   o_surv_seq1,
        output logic [seq_w-1:0]   o_surv_seq2
);

        logic [prob_w-1:0]  prob_sel;
        logic [char_w-1:0]  char_sel;
        logic [score_w-1:0] prod0, prod1, prod2;
        logic [cnt_w-1:0]   s1_idx;
        logic [slot_w-1:0]  s1_code;
        logic               s1_valid;
        logic [cnt_w-1:0]   best;
        logic [score_w-1:0] best_score;
        logic [seq_w-1:0]   best_seq;
        logic [seq_w-1:0]   new_seq;

        always_comb begin
                case (i_cand_idx)
                        2'd0:    begin prob_sel = i_prob0; char_sel = i_char0; end
                        2'd1:    begin prob_sel = i_prob1; char_sel = i_char1; end
                        default: begin prob_sel = i_prob2; char_sel = i_char2; end
                endcase
        end

        always_ff @(posedge i_clk or posedge i_rst_n) begin
                if (i_rst_n)
                        s1_valid <= 1'b0;
                else
                        s1_valid <= i_cand_valid;
        end

        // stage 1: beam x emission x transition, kept to 64 bits
        always_ff @(posedge i_clk) begin
                if (i_cand_valid) begin
                        prod0   <= i_score0 * score_w'(prob_sel) * score_w'(i_w0);
                        prod1   <= i_score1 * score_w'(prob_sel) * score_w'(i_w1);
                        prod2   <= i_score2 * score_w'(prob_sel) * score_w'(i_w2);
                        s1_idx  <= i_cand_idx;
                        s1_code <= slot_w'(char_sel) + slot_w'(1);
                end
        end

        assign best = best_idx(prod0, prod1, prod2);

        always_comb begin
                case (best)
                        2'd0:    begin best_score = prod0; best_seq = i_seq0; end
                        2'd1:    begin best_score = prod1; best_seq = i_seq1; end
                        default: begin best_score = prod2; best_seq = i_seq2; end
                endcase
        end

        assign new_seq = {best_seq[seq_w-slot_w-1:0], s1_code};   // oldest slot drops off

        // stage 2: survivor for candidate s1_idx
        always_ff @(posedge i_clk) begin
                if (s1_valid) begin
                        case (s1_idx)
                                2'd0: begin
                                        o_surv_score0 <= best_score;
                                        o_surv_seq0   <= new_seq;
                                end
                                2'd1: begin
                                        o_surv_score1 <= best_score;
                                        o_surv_seq1   <= new_seq;
                                end
                                default: begin
                                        o_surv_score2 <= best_score;
                                        o_surv_seq2   <= new_seq;
                                end
                        endcase
                end
        end

endmodule

`default_nettype wire

// ==== beam_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module beam_store import lm_pkg::*; import beam_pkg::*; (
        input  wire                i_clk,
        input  wire                i_rst_n,
        input  wire                i_seed_load,
        input  wire                i_beam_commit,
        input  wire                i_top_load,
        input  wire  [prob_w-1:0]  i_prob0,
        input  wire  [prob_w-1:0]  i_prob1,
        input  wire  [prob_w-1:0]  i_prob2,
        input  wire  [char_w-1:0]  i_char0,
        input  wire  [char_w-1:0]  i_char1,
        input  wire  [char_w-1:0]  i_char2,
        input  wire  [trans_w-1:0] i_w0,
        input  wire  [trans_w-1:0] i_w1,
        input  wire  [trans_w-1:0] i_w2,
        input  wire  [score_w-1:0] i_surv_score0,
        input  wire  [score_w-1:0] i_surv_score1,
        input  wire  [score_w-1:0] i_surv_score2,
        input  wire  [seq_w-1:0]   i_surv_seq0,
        input  wire  [seq_w-1:0]   i_surv_seq1,
        input  wire  [seq_w-1:0]   i_surv_seq2,
        output logic [score_w-1:0] o_score0,
        output logic [score_w-1:0] o_score1,
        output logic [score_w-1:0] o_score2,
        output logic [seq_w-1:0]   o_seq0,
        output logic [seq_w-1:0]   o_seq1,
        output logic [seq_w-1:0]   o_seq2,
        output logic [char_w-1:0]  o_last0,
        output logic [char_w-1:0]  o_last1,
        output logic [char_w-1:0]  o_last2,
        output logic [char_w-1:0]  o_char,
        output logic [seq_w-1:0]   o_seq,
        output logic               o_stepped
);

        logic [cnt_w-1:0] top;

        function automatic logic [score_w-1:0] seed_score(input logic [prob_w-1:0] prob,
                                                          input logic [trans_w-1:0] w);
                return (score_w'(prob) * score_w'(w)) >> norm_shift;
        endfunction

        always_ff @(posedge i_clk) begin
                if (i_seed_load) begin
                        o_score0 <= seed_score(i_prob0, i_w0);
                        o_score1 <= seed_score(i_prob1, i_w1);
                        o_score2 <= seed_score(i_prob2, i_w2);
                        o_seq0   <= seq_w'(i_char0) + seq_w'(1);   // single slot
                        o_seq1   <= seq_w'(i_char1) + seq_w'(1);
                        o_seq2   <= seq_w'(i_char2) + seq_w'(1);
                end else if (i_beam_commit) begin
                        o_score0 <= i_surv_score0 >> norm_shift;
                        o_score1 <= i_surv_score1 >> norm_shift;
                        o_score2 <= i_surv_score2 >> norm_shift;
                        o_seq0   <= i_surv_seq0;
                        o_seq1   <= i_surv_seq1;
                        o_seq2   <= i_surv_seq2;
                end
                if (i_seed_load || i_beam_commit) begin
                        o_last0 <= i_char0;
                        o_last1 <= i_char1;
                        o_last2 <= i_char2;
                end
        end

        assign top = best_idx(o_score0, o_score1, o_score2);

        always_ff @(posedge i_clk or posedge i_rst_n) begin
                if (i_rst_n) begin
                        o_char    <= '0;
                        o_seq     <= '0;
                        o_stepped <= 1'b0;
                end else begin
                        o_stepped <= i_top_load;
                        if (i_top_load) begin
                                case (top)
                                        2'd0: begin
                                                o_seq  <= o_seq0;
                                                o_char <= o_last0 + char_w'(1);
                                        end
                                        2'd1: begin
                                                o_seq  <= o_seq1;
                                                o_char <= o_last1 + char_w'(1);
                                        end
                                        default: begin
                                                o_seq  <= o_seq2;
                                                o_char <= o_last2 + char_w'(1);
                                        end
                                endcase
                        end
                end
        end

endmodule

`default_nettype wire

// ==== viterbi_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module viterbi_top import lm_pkg::*; import beam_pkg::*; (
        input  wire               i_clk,
        input  wire               i_rst_n,
        input  wire               i_start,
        input  wire               i_next,
        input  wire  [prob_w-1:0] i_prob0,
        input  wire  [prob_w-1:0] i_prob1,
        input  wire  [prob_w-1:0] i_prob2,
        input  wire  [char_w-1:0] i_char0,
        input  wire  [char_w-1:0] i_char1,
        input  wire  [char_w-1:0] i_char2,
        output logic [char_w-1:0] o_char,
        output logic [seq_w-1:0]  o_seq,
        output logic              o_stepped
);

        logic               seed_load, cand_valid, beam_commit, top_load;
        logic [cnt_w-1:0]   cand_idx;
        logic [trans_w-1:0] w0, w1, w2;
        logic [score_w-1:0] score0, score1, score2;
        logic [seq_w-1:0]   seq0, seq1, seq2;
        logic [char_w-1:0]  last0, last1, last2;
        logic [score_w-1:0] surv_score0, surv_score1, surv_score2;
        logic [seq_w-1:0]   surv_seq0, surv_seq1, surv_seq2;

        step_ctrl u_ctrl (
                .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start), .i_next(i_next),
                .o_seed_load(seed_load), .o_cand_valid(cand_valid), .o_cand_idx(cand_idx),
                .o_beam_commit(beam_commit), .o_top_load(top_load)
        );

        bigram_rom u_rom (
                .i_prev0(last0), .i_prev1(last1), .i_prev2(last2),
                .i_char0(i_char0), .i_char1(i_char1), .i_char2(i_char2),
                .i_cand_idx(cand_idx), .i_seed(seed_load),
                .o_w0(w0), .o_w1(w1), .o_w2(w2)
        );

        beam_scorer u_scorer (
                .i_clk(i_clk), .i_rst_n(i_rst_n),
                .i_cand_valid(cand_valid), .i_cand_idx(cand_idx),
                .i_prob0(i_prob0), .i_prob1(i_prob1), .i_prob2(i_prob2),
                .i_char0(i_char0), .i_char1(i_char1), .i_char2(i_char2),
                .i_score0(score0), .i_score1(score1), .i_score2(score2),
                .i_seq0(seq0), .i_seq1(seq1), .i_seq2(seq2),
                .i_w0(w0), .i_w1(w1), .i_w2(w2),
                .o_surv_score0(surv_score0), .o_surv_score1(surv_score1),
                .o_surv_score2(surv_score2),
                .o_surv_seq0(surv_seq0), .o_surv_seq1(surv_seq1), .o_surv_seq2(surv_seq2)
        );

        beam_store u_store (
                .i_clk(i_clk), .i_rst_n(i_rst_n),
                .i_seed_load(seed_load), .i_beam_commit(beam_commit), .i_top_load(top_load),
                .i_prob0(i_prob0), .i_prob1(i_prob1), .i_prob2(i_prob2),
                .i_char0(i_char0), .i_char1(i_char1), .i_char2(i_char2),
                .i_w0(w0), .i_w1(w1), .i_w2(w2),
                .i_surv_score0(surv_score0), .i_surv_score1(surv_score1),
                .i_surv_score2(surv_score2),
                .i_surv_seq0(surv_seq0), .i_surv_seq1(surv_seq1), .i_surv_seq2(surv_seq2),
                .o_score0(score0), .o_score1(score1), .o_score2(score2),
                .o_seq0(seq0), .o_seq1(seq1), .o_seq2(seq2),
                .o_last0(last0), .o_last1(last1), .o_last2(last2),
                .o_char(o_char), .o_seq(o_seq), .o_stepped(o_stepped)
        );

endmodule

`default_nettype wire

// ==== viterbi_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module viterbi_tb import lm_pkg::*; import beam_pkg::*; ();

        logic               i_clk;
        logic               i_rst_n;
        logic               i_start;
        logic               i_next;
        logic [prob_w-1:0]  i_prob0, i_prob1, i_prob2;
        logic [char_w-1:0]  i_char0, i_char1, i_char2;
        wire  [char_w-1:0]  o_char;
        wire  [seq_w-1:0]   o_seq;
        wire                o_stepped;

        // reference model
        logic [trans_w-1:0] wt [rom_depth];
        logic [score_w-1:0] m_score [n_beam];
        logic [seq_w-1:0]   m_seq [n_beam];
        logic [char_w-1:0]  m_last [n_beam];
        logic [char_w-1:0]  cur_c [n_beam];
        logic [prob_w-1:0]  cur_p [n_beam];

        logic [3:0]          q_cmd [$];
        logic [3*char_w-1:0] q_chars [$];
        logic [3*prob_w-1:0] q_probs [$];
        logic [char_w-1:0]   q_exp [$];

        logic [31:0]        rng;
        int                 cycles;
        int                 limit;

        viterbi_top DUT (
                .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start), .i_next(i_next),
                .i_prob0(i_prob0), .i_prob1(i_prob1), .i_prob2(i_prob2),
                .i_char0(i_char0), .i_char1(i_char1), .i_char2(i_char2),
                .o_char(o_char), .o_seq(o_seq), .o_stepped(o_stepped)
        );

        always #2 i_clk = ~i_clk;

        task automatic abort_run();
                $display("Simulation FAILED");
                $fatal(1, "stopping at first error");
        endtask

        task automatic check_eq(input string name, input logic [seq_w-1:0] got,
                                input logic [seq_w-1:0] exp);
                assert (got === exp) else begin
                        $display("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, exp);
                        abort_run();
                end
        endtask

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        function automatic logic [trans_w-1:0] weight(input int row, input logic [char_w-1:0] col);
                return wt[row * alpha_size + int'(col)];
        endfunction

        function automatic logic [slot_w-1:0] code_of(input logic [char_w-1:0] c);
                return slot_w'(c) + slot_w'(1);
        endfunction

        task automatic load_records();
                int          fd;
                int          n;
                string       line;
                logic [31:0] cmd, c0, c1, c2, p0, p1, p2, ex;
                fd = $fopen("step_input.txt", "r");
                if (fd == 0) begin
                        $display("could not open step_input.txt");
                        abort_run();
                end
                while (!$feof(fd)) begin
                        line = "";
                        n = $fgets(line, fd);
                        if (n > 1 && line.getc(0) != "#") begin
                                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                            cmd, c0, c1, c2, p0, p1, p2, ex);
                                if (n != 8) begin
                                        $display("malformed record in step_input.txt: %s", line);
                                        abort_run();
                                end
                                q_cmd.push_back(cmd[3:0]);
                                q_chars.push_back({c2[char_w-1:0], c1[char_w-1:0], c0[char_w-1:0]});
                                q_probs.push_back({p2, p1, p0});
                                q_exp.push_back(ex[char_w-1:0]);
                        end
                end
                $fclose(fd);
        endtask

        task automatic seed_model();
                for (int k = 0; k < n_beam; k++) begin
                        m_score[k] = (score_w'(cur_p[k]) * score_w'(weight(start_row, cur_c[k])))
                                     >> norm_shift;
                        m_seq[k]   = seq_w'(code_of(cur_c[k]));
                        m_last[k]  = cur_c[k];
                end
        endtask

        task automatic advance_model();
                logic [score_w-1:0] n_score [n_beam];
                logic [seq_w-1:0]   n_seq [n_beam];
                logic [score_w-1:0] prod;
                logic [score_w-1:0] best_p;
                int                 best_j;
                for (int k = 0; k < n_beam; k++) begin
                        best_p = '0;
                        best_j = 0;
                        for (int j = 0; j < n_beam; j++) begin
                                prod = m_score[j] * score_w'(cur_p[k])
                                       * score_w'(weight(int'(m_last[j]) + 1, cur_c[k]));
                                if (j == 0 || prod > best_p) begin   // strict, so ties keep lower j
                                        best_p = prod;
                                        best_j = j;
                                end
                        end
                        n_score[k] = best_p >> norm_shift;
                        n_seq[k]   = {m_seq[best_j][seq_w-slot_w-1:0], code_of(cur_c[k])};
                end
                for (int k = 0; k < n_beam; k++) begin
                        m_score[k] = n_score[k];
                        m_seq[k]   = n_seq[k];
                        m_last[k]  = cur_c[k];
                end
        endtask

        function automatic int top_beam();
                int t;
                t = 0;
                for (int j = 1; j < n_beam; j++)
                        if (m_score[j] > m_score[t])
                                t = j;
                return t;
        endfunction

        task automatic run_step(input logic [3:0] cmd, input logic [char_w-1:0] exp_char);
                int t;
                int lat;
                int want;
                i_char0 = cur_c[0];
                i_char1 = cur_c[1];
                i_char2 = cur_c[2];
                i_prob0 = cur_p[0];
                i_prob1 = cur_p[1];
                i_prob2 = cur_p[2];
                if (cmd == 4'd0)
                        i_start = 1'b1;
                else
                        i_next = 1'b1;
                @(negedge i_clk);
                i_start = 1'b0;
                i_next  = 1'b0;
                lat = 0;
                do begin
                        @(negedge i_clk);
                        lat++;
                        if (cmd == 4'd2 && lat == 2) begin      // both strobes while busy
                                i_start = 1'b1;
                                i_next  = 1'b1;
                        end else if (cmd == 4'd2 && lat == 3) begin
                                i_start = 1'b0;
                                i_next  = 1'b0;
                        end
                end while (!o_stepped);
                want = (cmd == 4'd0) ? 2 : 6;
                check_eq("o_stepped latency", seq_w'(lat), seq_w'(want));
                if (cmd == 4'd0)
                        seed_model();
                else
                        advance_model();
                t = top_beam();
                check_eq("o_seq", o_seq, m_seq[t]);
                check_eq("o_char", seq_w'(o_char), seq_w'(m_last[t] + char_w'(1)));
                if (exp_char != '0)
                        check_eq("o_char (file)", seq_w'(o_char), seq_w'(exp_char));
                @(negedge i_clk);
                check_eq("o_stepped", seq_w'(o_stepped), '0);   // one-cycle pulse
        endtask

        // run limit
        always @(posedge i_clk) begin
                cycles <= cycles + 1;
                if (limit != 0 && cycles >= limit) begin
                        $display("timeout: run did not finish within %0d cycles", limit);
                        abort_run();
                end
        end

        initial begin
                logic [3*char_w-1:0] chars;
                logic [3*prob_w-1:0] probs;
                i_clk    = 1'b0;
                i_rst_n  = 1'b1;
                i_start  = 1'b0;
                i_next   = 1'b0;
                i_prob0  = '0;
                i_prob1  = '0;
                i_prob2  = '0;
                i_char0  = '0;
                i_char1  = '0;
                i_char2  = '0;
                rng      = 32'heb70_271a;
                cycles   = 0;
                limit    = 0;
                $readmemh("bigram_table.hex", wt);
                load_records();
                limit = q_cmd.size() * 8 + 40;

                repeat (16) @(negedge i_clk);
                check_eq("o_stepped", seq_w'(o_stepped), '0);
                check_eq("o_char", seq_w'(o_char), '0);
                check_eq("o_seq", o_seq, '0);
                i_rst_n = 1'b0;
                repeat (4) begin
                        @(negedge i_clk);
                        check_eq("o_stepped", seq_w'(o_stepped), '0);   // no strobe yet
                end

                for (int r = 0; r < q_cmd.size(); r++) begin
                        chars = q_chars[r];
                        probs = q_probs[r];
                        for (int k = 0; k < n_beam; k++) begin
                                cur_c[k] = chars[k*char_w +: char_w];
                                cur_p[k] = probs[k*prob_w +: prob_w];
                                if (q_cmd[r] == 4'd3) begin
                                        rng      = xorshift32(rng);
                                        cur_p[k] = 32'h100 + (rng & 32'h1ff);
                                end
                        end
                        run_step(q_cmd[r], q_exp[r]);
                end

                $display("Simulation PASSED");
                $finish;
        end

endmodule

`default_nettype wire

// ==== bigram_table.hex ====
// bigram weights, row-major, 6 columns per row: row 0 is the start row,
// row r holds the weights that follow symbol r-1
1000
1000
1000
1000
1000
1000
0c00
1800
0900
1000
1000
1000
1400
0a00
1e00
1000
1000
1000
0800
1200
1600
1000
1000
1000
1a00
0e00
0b00
1c00
0d00
1100
0f00
1300
0a00
0c00
2000
0900
1100
0d00
1b00
0e00
0a00
1500

// ==== step_input.txt ====
# cmd c0 c1 c2 p0 p1 p2 exp, all hex; exp is the expected o_char, 0 when only the model decides
# cmd 0 start, 1 next, 2 next with a stray strobe while busy, 3 next with random emissions
0 0 1 2 00100000 00100000 00100000 1
1 3 4 5 00004000 00004000 00004000 4
2 0 2 4 00000100 00010000 00000100 3
1 1 5 3 00000080 00000080 00008000 4
0 5 2 0 00001000 00200000 00001000 3
3 1 3 5 00000000 00000000 00000000 0
1 4 0 2 00000010 00000400 00000010 1
3 2 5 1 00000000 00000000 00000000 0
3 0 3 4 00000000 00000000 00000000 0
1 5 2 3 00000400 00000010 00000010 6
3 1 4 0 00000000 00000000 00000000 0
2 3 0 5 00000010 00000010 00000400 6
3 2 1 4 00000000 00000000 00000000 0
3 5 3 0 00000000 00000000 00000000 0
1 0 4 2 00000010 00000400 00000010 5
3 4 2 1 00000000 00000000 00000000 0
3 3 5 0 00000000 00000000 00000000 0
1 1 2 3 00000400 00000010 00000010 2
3 0 1 5 00000000 00000000 00000000 0
1 2 3 4 00000010 00000010 00000400 5
3 5 0 3 00000000 00000000 00000000 0

// ==== build.f ====
lm_pkg.sv
beam_pkg.sv
bigram_rom.sv
step_ctrl.sv
beam_scorer.sv
beam_store.sv
viterbi_top.sv
viterbi_tb.sv

// ==== Makefile ====
.PHONY: all run clean

all: run

# rebuilt whenever a source in the file list changes
obj_dir/Vviterbi_tb: build.f $(shell cat build.f)
	verilator --binary --timing --assert --top-module viterbi_tb -f build.f

run: obj_dir/Vviterbi_tb
	./obj_dir/Vviterbi_tb

clean:
	rm -rf obj_dir
